//--- vlog.f
src/alioth_pkg.sv
src/itcm.sv
src/ifu.sv
src/gpr.sv
src/exu.sv
src/tohost_monitor.sv
src/fpga_top.sv
dv/verdict_checker.sv
dv/tb_fpga_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fpga_top testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f vlog.f \
    --top-module tb_fpga_top --Mdir obj_dir -o sim_tb_fpga_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_fpga_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- dv/fpga_testdata.txt
# test <name> <pass|fail|none> opens a test and end closes it
# w <byte address> <instruction> loads one itcm word, both in hex
test addi_pass pass
w 00000000 00100193  # addi x3, x0, 1
w 00000004 00800293  # addi x5, x0, 8
w 00000008 0380006f  # jal  x0, 0x40
w 00000040 fff28293  # addi x5, x5, -1
w 00000044 fe029ee3  # bne  x5, x0, 0x40
w 00000048 0000006f  # jal  x0, 0x48
end
test addi_fail fail
w 00000000 00200193  # addi x3, x0, 2
w 00000004 00800293  # addi x5, x0, 8
w 00000008 0380006f  # jal  x0, 0x40
w 00000040 fff28293  # addi x5, x5, -1
w 00000044 fe029ee3  # bne  x5, x0, 0x40
w 00000048 0000006f  # jal  x0, 0x48
end
test arith_check pass
w 00000000 123450b7  # lui  x1, 0x12345
w 00000004 67808093  # addi x1, x1, 0x678
w 00000008 12300113  # addi x2, x0, 0x123
w 0000000c 00208233  # add  x4, x1, x2
w 00000010 40120333  # sub  x6, x4, x1
w 00000014 123453b7  # lui  x7, 0x12345
w 00000018 79b38393  # addi x7, x7, 0x79b
w 0000001c 40410433  # sub  x8, x2, x4
w 00000020 edcbb4b7  # lui  x9, 0xedcbb
w 00000024 98848493  # addi x9, x9, -0x678
w 00000028 00200193  # addi x3, x0, 2
w 0000002c 00800293  # addi x5, x0, 8
w 00000030 00721863  # bne  x4, x7, 0x40
w 00000034 00231663  # bne  x6, x2, 0x40
w 00000038 00941463  # bne  x8, x9, 0x40
w 0000003c 00100193  # addi x3, x0, 1
w 00000040 fff28293  # addi x5, x5, -1
w 00000044 fe029ee3  # bne  x5, x0, 0x40
w 00000048 0000006f  # jal  x0, 0x48
end
test jal_beq_link pass
w 00000000 00800293  # addi x5, x0, 8
w 00000004 00c000ef  # jal  x1, 0x10
w 00000008 00200193  # addi x3, x0, 2
w 0000000c 0000006f  # jal  x0, 0x0c
w 00000010 ff908193  # addi x3, x1, -7
w 00000014 02000663  # beq  x0, x0, 0x40
w 00000018 0000006f  # jal  x0, 0x18
w 00000040 fff28293  # addi x5, x5, -1
w 00000044 fe029ee3  # bne  x5, x0, 0x40
w 00000048 0000006f  # jal  x0, 0x48
end
test seven_visits none
w 00000000 00100193  # addi x3, x0, 1
w 00000004 00700293  # addi x5, x0, 7
w 00000008 0380006f  # jal  x0, 0x40
w 00000040 fff28293  # addi x5, x5, -1
w 00000044 fe029ee3  # bne  x5, x0, 0x40
w 00000048 0000006f  # jal  x0, 0x48
end
test self_loop_tohost pass
w 00000000 00100193  # addi x3, x0, 1
w 00000004 00700293  # addi x5, x0, 7
w 00000008 0380006f  # jal  x0, 0x40
w 00000040 00028063  # beq  x5, x0, 0x40
w 00000044 fff28293  # addi x5, x5, -1
w 00000048 ff9ff06f  # jal  x0, 0x40
end

//--- dv/tb_fpga_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_top;

    import alioth_pkg::*;

    localparam int unsigned WATCH_CYCLES = 2000;   // per-test led window
    localparam int unsigned TEXT_W       = 8 * 24;

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  load_en;
    pc_t   load_addr;
    word_t load_data;
    logic  led_pass;
    logic  led_fail;

    logic              start;
    logic [TEXT_W-1:0] test_name;
    logic [63:0]       verdict;
    logic [31:0]       checked_count;
    logic [31:0]       pass_count;
    logic [31:0]       fail_count;
    int                tb_errors;
    int                tests_run;

    fpga_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .led_pass  (led_pass),
        .led_fail  (led_fail)
    );

    verdict_checker checker_i (
        .clk           (clk),
        .start         (start),
        .test_name     (test_name),
        .verdict       (verdict),
        .cycle_limit   (WATCH_CYCLES),
        .led_pass      (led_pass),
        .led_fail      (led_fail),
        .checked_count (checked_count),
        .pass_count    (pass_count),
        .fail_count    (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        step();
        run     = 1'b0;
        load_en = 1'b0;
        rst_n   = 1'b0;
        repeat (2) step();
        rst_n = 1'b1;
    endtask

    task automatic load_word(input pc_t addr, input word_t data);
        step();
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    // start the core and hand the window over to the checker
    task automatic run_program();
        logic [31:0] prev;
        int unsigned waited;
        step();
        load_en = 1'b0;
        run     = 1'b1;
        start   = 1'b1;
        prev    = checked_count;
        step();
        start  = 1'b0;
        waited = 0;
        while ((checked_count == prev) && (waited < WATCH_CYCLES + 50)) begin
            @(negedge clk);
            waited++;
        end
        if (checked_count == prev) begin
            $display("%0s: checker gave no result in time", test_name);
            tb_errors++;
        end
        step();
        run = 1'b0;
    endtask

    initial begin
        int                fd;
        int                n;
        logic [TEXT_W-1:0] kind;
        logic [1023:0]     rest;
        pc_t               addr;
        word_t             data;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        test_name = '0;
        verdict   = '0;
        tb_errors = 0;
        tests_run = 0;
        fd = $fopen("dv/fpga_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/fpga_testdata.txt");
            tb_errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    n = $fgets(rest, fd);  // rest of a comment
                end else if (kind == "test") begin
                    n = $fscanf(fd, "%s %s", test_name, verdict);
                    if (n != 2) begin
                        $display("malformed test header in test data");
                        tb_errors++;
                    end
                    apply_reset();
                end else if (kind == "w") begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    if (n != 2) begin
                        $display("%0s: malformed word record", test_name);
                        tb_errors++;
                    end
                    load_word(addr, data);
                end else if (kind == "end") begin
                    run_program();
                    tests_run++;
                end else begin
                    $display("unknown record %0s in test data", kind);
                    tb_errors++;
                end
            end
            $fclose(fd);
        end
        step();
        $display("tests %0d, passed %0d, failed %0d, testbench errors %0d",
                 tests_run, pass_count, fail_count, tb_errors);
        if ((tb_errors == 0) && (fail_count == 0) && (tests_run > 0)
            && (pass_count == tests_run)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_fpga_top

`default_nettype wire

//--- dv/verdict_checker.sv
`timescale 1ns/1ps
`default_nettype none

module verdict_checker (
    input  logic         clk,
    input  logic         start,        // one-cycle pulse per test
    input  logic [191:0] test_name,
    input  logic [63:0]  verdict,      // pass, fail or none as text
    input  logic [31:0]  cycle_limit,
    input  logic         led_pass,
    input  logic         led_fail,
    output logic [31:0]  checked_count,
    output logic [31:0]  pass_count,
    output logic [31:0]  fail_count
);

    int unsigned n_checked = 0;
    int unsigned n_pass    = 0;
    int unsigned n_fail    = 0;

    assign checked_count = n_checked;
    assign pass_count    = n_pass;
    assign fail_count    = n_fail;

    // one led against its expected level
    function automatic logic led_matches(input logic [191:0] name, input string sig,
                                         input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[FAIL] %0s: %0s expected 0x%h, got 0x%h", name, sig, expected, actual);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // leds change on the rising edge and are stable by the falling one
    always @(negedge clk) begin
        logic        exp_pass;
        logic        exp_fail;
        logic        ok;
        int unsigned waited;
        if (start) begin
            exp_pass = (verdict == "pass");
            exp_fail = (verdict == "fail");
            waited   = 0;
            // a none test has to sit out the whole window
            while (!(led_pass || led_fail) && (waited < cycle_limit)) begin
                @(negedge clk);
                waited++;
            end
            if (!(led_pass || led_fail)) begin
                ok = !(exp_pass || exp_fail);
                if (!ok) begin
                    $display("%0s: no LED lit within %0d cycles", test_name, cycle_limit);
                end
            end else begin
                ok = led_matches(test_name, "led_pass", exp_pass, led_pass);
                if (ok) begin
                    ok = led_matches(test_name, "led_fail", exp_fail, led_fail);
                end
            end
            if (ok) begin
                $display("[PASS] %0s", test_name);
                n_pass++;
            end else begin
                n_fail++;
            end
            n_checked++;  // tells the testbench this test is done
        end
    end

endmodule : verdict_checker

`default_nettype wire

//--- src/fpga_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_top #(
    parameter int unsigned     ITCM_ADDR_WIDTH = 10,
    parameter alioth_pkg::pc_t TOHOST_PC       = alioth_pkg::TOHOST_PC_DEFAULT,
    parameter int unsigned     TOHOST_COUNT    = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,        // core enable level
    input  logic              load_en,    // itcm load strobe
    input  alioth_pkg::pc_t   load_addr,
    input  alioth_pkg::word_t load_data,
    output logic              led_pass,
    output logic              led_fail
);

    import alioth_pkg::*;

    pc_t      pc;
    word_t    instr;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     rd_we;
    reg_idx_t rd_idx;
    word_t    rd_data;
    logic     redirect;
    pc_t      redirect_pc;
    word_t    x3_value;

    itcm #(
        .ITCM_ADDR_WIDTH (ITCM_ADDR_WIDTH)
    ) itcm_i (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (pc),
        .instr      (instr)
    );

    ifu #(
        .ITCM_ADDR_WIDTH (ITCM_ADDR_WIDTH)
    ) ifu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    gpr gpr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),      // no write-back while idle
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_we    (rd_we),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .x3_value (x3_value)
    );

    exu exu_i (
        .pc          (pc),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_we       (rd_we),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    tohost_monitor #(
        .TOHOST_PC    (TOHOST_PC),
        .TOHOST_COUNT (TOHOST_COUNT)
    ) tohost_monitor_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc       (pc),
        .x3_value (x3_value),
        .led_pass (led_pass),
        .led_fail (led_fail)
    );

endmodule : fpga_top

`default_nettype wire

//--- src/tohost_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tohost_monitor #(
    parameter alioth_pkg::pc_t TOHOST_PC    = alioth_pkg::TOHOST_PC_DEFAULT,
    parameter int unsigned     TOHOST_COUNT = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  alioth_pkg::pc_t   pc,
    input  alioth_pkg::word_t x3_value,
    output logic              led_pass,
    output logic              led_fail
);

    import alioth_pkg::*;

    localparam int unsigned CNT_W = $clog2(TOHOST_COUNT + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(TOHOST_COUNT);

    pc_t             prev_pc;
    logic [CNT_W-1:0] arrive_cnt;
    logic            arrival;
    logic            verdict_done;

    // a self-loop on tohost only counts once
    assign arrival = (pc == TOHOST_PC) && (pc != prev_pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_pc    <= '0;
            arrive_cnt <= '0;
        end else begin
            prev_pc <= pc;
            if (arrival && (arrive_cnt != CNT_END)) begin
                arrive_cnt <= arrive_cnt + 1'b1;  // saturates at the end count
            end
        end
    end

    // one-shot verdict, leds hold until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            verdict_done <= 1'b0;
            led_pass     <= 1'b0;
            led_fail     <= 1'b0;
        end else if ((arrive_cnt == CNT_END) && !verdict_done) begin
            verdict_done <= 1'b1;
            led_pass     <= (x3_value == 32'd1);
            led_fail     <= (x3_value != 32'd1);
        end
    end

endmodule : tohost_monitor

`default_nettype wire

//--- src/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  alioth_pkg::pc_t      pc,
    input  alioth_pkg::word_t    instr,
    input  alioth_pkg::word_t    rs1_data,
    input  alioth_pkg::word_t    rs2_data,
    output alioth_pkg::reg_idx_t rs1_idx,
    output alioth_pkg::reg_idx_t rs2_idx,
    output logic                 rd_we,
    output alioth_pkg::reg_idx_t rd_idx,
    output alioth_pkg::word_t    rd_data,
    output logic                 redirect,
    output alioth_pkg::pc_t      redirect_pc
);

    import alioth_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    word_t imm_i;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;

    alu_op_e alu_op;
    logic    use_imm;   // second operand from imm_i
    word_t   op_b;
    logic    rs_equal;
    pc_t     br_target;
    pc_t     jal_target;

    // instruction fields
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs_equal   = (rs1_data == rs2_data);
    assign br_target  = pc + imm_b;
    assign jal_target = pc + imm_j;

    // decode, anything unrecognised falls through as a no-op
    always_comb begin
        rd_we       = 1'b0;
        alu_op      = ALU_ADD;
        use_imm     = 1'b0;
        redirect    = 1'b0;
        redirect_pc = br_target;

        case (opcode)
            OPC_LUI: begin
                rd_we  = 1'b1;
                alu_op = ALU_PASS_IMM;
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD_SUB) begin  // addi only
                    rd_we   = 1'b1;
                    use_imm = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct3 == F3_ADD_SUB) begin
                    if (funct7 == F7_ADD) begin
                        rd_we = 1'b1;
                    end else if (funct7 == F7_SUB) begin
                        rd_we  = 1'b1;
                        alu_op = ALU_SUB;
                    end
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  redirect = rs_equal;
                    F3_BNE:  redirect = !rs_equal;
                    default: redirect = 1'b0;  // other compares unsupported
                endcase
            end
            OPC_JAL: begin
                rd_we       = 1'b1;
                alu_op      = ALU_LINK;
                redirect    = 1'b1;
                redirect_pc = jal_target;
            end
            default: ;
        endcase
    end

    assign op_b = use_imm ? imm_i : rs2_data;

    // write-back value
    always_comb begin
        case (alu_op)
            ALU_ADD:      rd_data = rs1_data + op_b;
            ALU_SUB:      rd_data = rs1_data - op_b;
            ALU_PASS_IMM: rd_data = imm_u;
            ALU_LINK:     rd_data = pc + 32'd4;  // return address
            default:      rd_data = '0;
        endcase
    end

endmodule : exu

`default_nettype wire

//--- src/gpr.sv
`timescale 1ns/1ps
`default_nettype none

module gpr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  alioth_pkg::reg_idx_t rs1_idx,
    input  alioth_pkg::reg_idx_t rs2_idx,
    input  logic                 rd_we,
    input  alioth_pkg::reg_idx_t rd_idx,
    input  alioth_pkg::word_t    rd_data,
    output alioth_pkg::word_t    rs1_data,
    output alioth_pkg::word_t    rs2_data,
    output alioth_pkg::word_t    x3_value
);

    import alioth_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (run && rd_we && (rd_idx != 5'd0)) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];
    assign x3_value = regs[3];  // tohost verdict register

endmodule : gpr

`default_nettype wire

//--- src/ifu.sv
`timescale 1ns/1ps
`default_nettype none

module ifu #(
    parameter int unsigned ITCM_ADDR_WIDTH = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            redirect,
    input  alioth_pkg::pc_t redirect_pc,
    output alioth_pkg::pc_t pc
);

    import alioth_pkg::*;

    // keeps sequential fetch inside the itcm window
    localparam pc_t PC_MASK = pc_t'((64'd1 << ITCM_ADDR_WIDTH) - 64'd1);

    pc_t pc_seq;
    pc_t pc_next;

    assign pc_seq = (pc + 32'd4) & PC_MASK;

    // branch or jump wins over fall-through
    always_comb begin
        if (!run) begin
            pc_next = '0;  // parked at reset vector while idle
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule : ifu

`default_nettype wire

//--- src/itcm.sv
`timescale 1ns/1ps
`default_nettype none

module itcm #(
    parameter int unsigned ITCM_ADDR_WIDTH = 10
) (
    input  logic              clk,
    input  logic              load_en,
    input  alioth_pkg::pc_t   load_addr,
    input  alioth_pkg::word_t load_data,
    input  alioth_pkg::pc_t   fetch_addr,
    output alioth_pkg::word_t instr
);

    import alioth_pkg::*;

    localparam int unsigned DEPTH = 1 << (ITCM_ADDR_WIDTH - 2);  // words

    // program image indexed by word
    word_t mem [DEPTH];

    logic [ITCM_ADDR_WIDTH-3:0] load_widx;
    logic [ITCM_ADDR_WIDTH-3:0] fetch_widx;

    assign load_widx  = load_addr[ITCM_ADDR_WIDTH-1:2];   // drop byte offset
    assign fetch_widx = fetch_addr[ITCM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk) begin
        if (load_en) mem[load_widx] <= load_data;
    end

    assign instr = mem[fetch_widx];  // same-cycle fetch

endmodule : itcm

`default_nettype wire

//--- src/alioth_pkg.sv
`default_nettype none

package alioth_pkg;

    // data and instruction word
    typedef logic [31:0] word_t;

    // byte address seen by the fetch unit
    typedef logic [31:0] pc_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // write-back value selection
    typedef enum logic [1:0] {
        ALU_ADD      = 2'd0,  // rs1 + rs2 or rs1 + imm
        ALU_SUB      = 2'd1,  // rs1 - rs2
        ALU_PASS_IMM = 2'd2,  // upper immediate for lui
        ALU_LINK     = 2'd3   // return address for jal
    } alu_op_e;

    // rv32i major opcodes, only the subset the core decodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values inside the decoded opcodes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values for OP
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // test programs park here to signal the end of a run
    localparam pc_t TOHOST_PC_DEFAULT = 32'h0000_0040;

endpackage : alioth_pkg

`default_nettype wire
